// File: build.f
hw/denise_pkg.sv
hw/denise_regs.sv
hw/color_table.sv
hw/ham_generator.sv
hw/collision_detect.sv
hw/video_mixer.sv
hw/denise_top.sv
tests/denise_props.sv
tests/tb_denise.sv

// File: hw/collision_detect.sv
// collision control, plane and sprite match logic and the sticky clxdat register
`timescale 1ns/1ps
`default_nettype none

module collision_detect
(
	input wire clk,
	input wire reset,
	input denise_pkg::reg_bus_t bus,
	input denise_pkg::pixel_t pixel,
	output logic [15:0] clx_read_data // zero unless clxdat is read
);

	logic [15:0] clxcon;   // 15:12 odd sprite enables, 11:6 plane enables, 5:0 match
	logic [14:0] clxdat;   // sticky collision pairs
	logic [14:0] clx_now;  // pairs colliding on this pixel
	logic [5:0] plane_ok;  // per plane, matches or is not compared
	logic [3:0] spr_match; // per sprite pair
	logic odd_match;
	logic even_match;
	logic clxdat_read;

	assign clxdat_read = bus.strobe && !bus.write && bus.addr == denise_pkg::REG_CLXDAT;

	// --------------------
	// clxcon
	always_ff @(posedge clk)
	begin
		if (reset)
			clxcon <= denise_pkg::CLXCON_RESET;
		else if (bus.strobe && bus.write && bus.addr == denise_pkg::REG_CLXCON)
			clxcon <= bus.data;
	end

	// --------------------
	// plane match, bit equal to match value or plane disabled
	assign plane_ok = ~(pixel.bitplanes ^ clxcon[5:0]) | ~clxcon[11:6];
	assign odd_match = plane_ok[4] & plane_ok[2] & plane_ok[0];  // planes 1,3,5
	assign even_match = plane_ok[5] & plane_ok[3] & plane_ok[1]; // planes 2,4,6

	// even sprite always counts, odd one only when enabled
	always_comb
	begin
		for (int i = 0; i < 4; i++)
			spr_match[i] = pixel.sprite_active[2*i] |
				(pixel.sprite_active[2*i+1] & clxcon[12+i]);
	end

	// --------------------
	// the 15 pairs in clxdat bit order
	assign clx_now[0] = even_match & odd_match;
	assign clx_now[1] = odd_match & spr_match[0];
	assign clx_now[2] = odd_match & spr_match[1];
	assign clx_now[3] = odd_match & spr_match[2];
	assign clx_now[4] = odd_match & spr_match[3];
	assign clx_now[5] = even_match & spr_match[0];
	assign clx_now[6] = even_match & spr_match[1];
	assign clx_now[7] = even_match & spr_match[2];
	assign clx_now[8] = even_match & spr_match[3];
	assign clx_now[9] = spr_match[0] & spr_match[1];  // sprites 0/1 vs 2/3
	assign clx_now[10] = spr_match[0] & spr_match[2];
	assign clx_now[11] = spr_match[0] & spr_match[3];
	assign clx_now[12] = spr_match[1] & spr_match[2];
	assign clx_now[13] = spr_match[1] & spr_match[3];
	assign clx_now[14] = spr_match[2] & spr_match[3]; // sprites 4/5 vs 6/7

	// accumulate, a read restarts from the pixel of the read cycle
	always_ff @(posedge clk)
	begin
		if (clxdat_read)
			clxdat <= clx_now;
		else
			clxdat <= clxdat | clx_now;
	end

	// bit 15 always reads as one
	assign clx_read_data = clxdat_read ? {1'b1, clxdat} : 16'd0;

endmodule

`default_nettype wire

// File: hw/color_table.sv
// 32-entry colour palette with extra-half-brite halving on select bit 5
`timescale 1ns/1ps
`default_nettype none

module color_table
(
	input wire clk,
	input denise_pkg::reg_bus_t bus,
	input wire [5:0] palette_select, // bit 5 selects half brite
	output denise_pkg::rgb_t palette_rgb
);

	denise_pkg::rgb_t palette [denise_pkg::COLOR_COUNT]; // colour registers
	denise_pkg::rgb_t sel_color;                         // entry before EHB
	logic color_write;

	// --------------------
	// write port, any of the 32 words above color_base
	assign color_write = bus.strobe && bus.write &&
		({bus.addr[7:5], 5'd0} == denise_pkg::REG_COLOR_BASE);

	always_ff @(posedge clk)
	begin
		if (color_write)
			palette[bus.addr[4:0]] <= denise_pkg::rgb_t'(bus.data[11:0]); // top nibble unused
	end

	// --------------------
	// asynchronous read
	assign sel_color = palette[palette_select[4:0]];

	// half brite, each component shifted down one
	always_comb
	begin
		if (palette_select[5])
		begin
			palette_rgb.red = {1'b0, sel_color.red[3:1]};
			palette_rgb.green = {1'b0, sel_color.green[3:1]};
			palette_rgb.blue = {1'b0, sel_color.blue[3:1]};
		end
		else
			palette_rgb = sel_color; // normal colour
	end

endmodule

`default_nettype wire

// File: hw/denise_pkg.sv
// shared constants, register map and bus/pixel/colour types for the colour path
`default_nettype none

package denise_pkg;

	// --------------------
	// sizes and fixed values
	localparam int COLOR_COUNT = 32;                  // main palette entries
	localparam int HAM_COLOR_COUNT = 16;              // HAM base palette entries
	localparam logic [15:0] CLXCON_RESET = 16'h0fff;  // all planes compared, odd sprites out
	localparam logic [15:0] DENISE_ID = 16'hffff;     // chip id read-back
	localparam logic [2:0] NO_SPRITE_CODE = 3'd7;     // priority code with no sprite showing

	// --------------------
	// register word addresses (byte address shifted right by one)
	typedef enum logic [7:0] {
		REG_CLXDAT     = 8'h07, // collision data, read clears
		REG_DENISEID   = 8'h3e, // chip id
		REG_CLXCON     = 8'h4c, // collision control
		REG_BPLCON0    = 8'h80, // mode bits, HAM in bit 11
		REG_BPLCON2    = 8'h82, // playfield priority
		REG_COLOR_BASE = 8'hc0  // colour 0, palette runs on for 32 words
	} reg_addr_e;

	// HAM control code taken from bitplanes 5 and 4
	typedef enum logic [1:0] {
		HAM_LOAD      = 2'b00, // load from HAM palette
		HAM_MOD_BLUE  = 2'b01, // hold red and green
		HAM_MOD_RED   = 2'b10, // hold green and blue
		HAM_MOD_GREEN = 2'b11  // hold red and blue
	} ham_op_e;

	// --------------------
	// register bus, one strobe per access, no write bit means read
	typedef struct packed {
		logic strobe;
		logic write;
		logic [7:0] addr;  // word address
		logic [15:0] data; // write data
	} reg_bus_t;

	// one lores pixel from the external shifters
	typedef struct packed {
		logic [5:0] bitplanes;
		logic [7:0] sprite_active; // one bit per sprite
		logic [3:0] sprite_data;   // colour of the front sprite pair
	} pixel_t;

	// 12-bit colour, red in the top nibble like the palette words
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

endpackage

`default_nettype wire

// File: hw/denise_regs.sv
// mode and priority registers plus the read-data mux with the chip id
`timescale 1ns/1ps
`default_nettype none

module denise_regs
(
	input wire clk,
	input wire reset,
	input denise_pkg::reg_bus_t bus,
	input wire [15:0] clx_read_data, // from collision block, zero when not addressed
	output logic ham_mode,
	output logic [2:0] pf_priority,
	output logic [15:0] read_data
);

	logic bus_write; // write strobe this cycle
	logic bus_read;  // read strobe this cycle

	assign bus_write = bus.strobe & bus.write;
	assign bus_read = bus.strobe & ~bus.write;

	// --------------------
	// bplcon0, only the HAM bit is kept
	always_ff @(posedge clk)
	begin
		if (reset)
			ham_mode <= 1'b0;
		else if (bus_write && bus.addr == denise_pkg::REG_BPLCON0)
			ham_mode <= bus.data[11];
	end

	// bplcon2, playfield priority field
	always_ff @(posedge clk)
	begin
		if (reset)
			pf_priority <= 3'd0;
		else if (bus_write && bus.addr == denise_pkg::REG_BPLCON2)
			pf_priority <= bus.data[2:0]; // pf2 bits dropped
	end

	// --------------------
	// read mux, every source is zero unless addressed so OR is enough
	always_comb
	begin
		read_data = clx_read_data;
		if (bus_read && bus.addr == denise_pkg::REG_DENISEID)
			read_data = read_data | denise_pkg::DENISE_ID;
	end

endmodule

`default_nettype wire

// File: hw/denise_top.sv
// top of the colour path, register bus in, pixel stream in, 12-bit RGB out
`timescale 1ns/1ps
`default_nettype none

module denise_top
(
	input wire clk,
	input wire reset,
	input denise_pkg::reg_bus_t bus,
	input denise_pkg::pixel_t pixel,
	input wire blank,
	output logic [15:0] read_data,
	output denise_pkg::rgb_t rgb
);

	logic ham_mode;
	logic [2:0] pf_priority;
	logic [15:0] clx_read_data;
	logic [5:0] palette_select;
	denise_pkg::rgb_t palette_rgb;
	denise_pkg::rgb_t ham_rgb;

	// --------------------
	// registers and read mux
	denise_regs i_denise_regs (
		.clk           (clk),
		.reset         (reset),
		.bus           (bus),
		.clx_read_data (clx_read_data),
		.ham_mode      (ham_mode),
		.pf_priority   (pf_priority),
		.read_data     (read_data)
	);

	color_table i_color_table (
		.clk            (clk),
		.bus            (bus),
		.palette_select (palette_select),
		.palette_rgb    (palette_rgb)
	);

	ham_generator i_ham_generator (
		.clk       (clk),
		.bus       (bus),
		.bitplanes (pixel.bitplanes),
		.ham_rgb   (ham_rgb)
	);

	collision_detect i_collision_detect (
		.clk           (clk),
		.reset         (reset),
		.bus           (bus),
		.pixel         (pixel),
		.clx_read_data (clx_read_data)
	);

	// --------------------
	// pixel path
	video_mixer i_video_mixer (
		.clk            (clk),
		.reset          (reset),
		.pixel          (pixel),
		.ham_mode       (ham_mode),
		.pf_priority    (pf_priority),
		.blank          (blank),
		.ham_rgb        (ham_rgb),
		.palette_rgb    (palette_rgb),
		.palette_select (palette_select),
		.rgb            (rgb)
	);

endmodule

`default_nettype wire

// File: hw/ham_generator.sv
// hold-and-modify colour register with its own copy of the first 16 colours
`timescale 1ns/1ps
`default_nettype none

module ham_generator
(
	input wire clk,
	input denise_pkg::reg_bus_t bus,
	input wire [5:0] bitplanes,     // raw pixel of this cycle
	output denise_pkg::rgb_t ham_rgb
);

	denise_pkg::rgb_t ham_palette [denise_pkg::HAM_COLOR_COUNT];
	denise_pkg::rgb_t base_color; // palette entry picked by the low four bits
	denise_pkg::ham_op_e ham_op;
	logic ham_write;

	// --------------------
	// shadow palette written from the same words as colours 0 to 15
	// kept separate so sprites can use the main table at the same time
	assign ham_write = bus.strobe && bus.write &&
		({bus.addr[7:4], 4'd0} == denise_pkg::REG_COLOR_BASE);

	always_ff @(posedge clk)
	begin
		if (ham_write)
			ham_palette[bus.addr[3:0]] <= denise_pkg::rgb_t'(bus.data[11:0]);
	end

	assign base_color = ham_palette[bitplanes[3:0]];
	assign ham_op = denise_pkg::ham_op_e'(bitplanes[5:4]); // control code

	// --------------------
	// colour register that updates in step with the mixer delay stage
	always_ff @(posedge clk)
	begin
		case (ham_op)
			denise_pkg::HAM_LOAD:
				ham_rgb <= base_color;
			denise_pkg::HAM_MOD_BLUE:
				ham_rgb.blue <= bitplanes[3:0];  // red and green held
			denise_pkg::HAM_MOD_RED:
				ham_rgb.red <= bitplanes[3:0];   // green and blue held
			denise_pkg::HAM_MOD_GREEN:
				ham_rgb.green <= bitplanes[3:0]; // red and blue held
		endcase
	end

endmodule

`default_nettype wire

// File: hw/video_mixer.sv
// sprite priority, one-pixel delay, colour source select and blanked RGB output
`timescale 1ns/1ps
`default_nettype none

module video_mixer
(
	input wire clk,
	input wire reset,
	input denise_pkg::pixel_t pixel,
	input wire ham_mode,
	input wire [2:0] pf_priority,  // codes above this go behind the playfield
	input wire blank,
	input denise_pkg::rgb_t ham_rgb,
	input denise_pkg::rgb_t palette_rgb,
	output logic [5:0] palette_select,
	output denise_pkg::rgb_t rgb
);

	logic [3:0] spr_group; // any sprite of a pair active
	logic [2:0] spr_code;  // 1 to 4, or no sprite
	logic pf_valid;        // any bitplane set
	logic spr_sel;         // sprite wins this pixel
	logic spr_sel_d;
	logic [3:0] spr_data_d;
	logic [5:0] bitplanes_d;
	denise_pkg::rgb_t out_rgb;

	// --------------------
	// priority encoder, lowest pair in front
	always_comb
	begin
		for (int i = 0; i < 4; i++)
			spr_group[i] = |pixel.sprite_active[2*i +: 2];
		if (spr_group[0])
			spr_code = 3'd1;
		else if (spr_group[1])
			spr_code = 3'd2;
		else if (spr_group[2])
			spr_code = 3'd3;
		else if (spr_group[3])
			spr_code = 3'd4;
		else
			spr_code = denise_pkg::NO_SPRITE_CODE;
	end

	assign pf_valid = |pixel.bitplanes; // single playfield

	// playfield in front only where it has data
	assign spr_sel = (spr_code != denise_pkg::NO_SPRITE_CODE) &&
		!(pf_valid && spr_code > pf_priority);

	// --------------------
	// delay stage, lines up with the HAM register
	always_ff @(posedge clk)
	begin
		if (reset)
			spr_sel_d <= 1'b0;
		else
			spr_sel_d <= spr_sel;
	end

	always_ff @(posedge clk)
	begin
		spr_data_d <= pixel.sprite_data;
		bitplanes_d <= pixel.bitplanes;
	end

	// --------------------
	// palette select, sprites use entries 16 to 31
	assign palette_select = (ham_mode || spr_sel_d) ? {2'b01, spr_data_d} : bitplanes_d;

	// HAM colour unless a sprite covers it
	assign out_rgb = (ham_mode && !spr_sel_d) ? ham_rgb : palette_rgb;

	// output register with blanking
	always_ff @(posedge clk)
	begin
		if (reset || blank)
			rgb <= '0; // black
		else
			rgb <= out_rgb;
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the colour path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_denise \
	-Mdir obj_dir -o tb_denise
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_denise > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Some tests failed" sim.log; then
	exit 1
fi
if ! grep -q "All tests passed" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

// File: tests/denise_props.sv
// bound checks on blanking and reset behaviour of the video mixer
`timescale 1ns/1ps
`default_nettype none

module denise_props
(
	input wire clk,
	input wire reset,
	input wire blank,
	input wire ham_mode,
	input denise_pkg::rgb_t rgb
);

	// --------------------
	// blanking forces black on the next edge
	blank_gives_black: assert property (@(posedge clk) blank |=> rgb == 12'h000)
		else $error("rgb not black one cycle after blank");

	// reset clears the output register
	reset_gives_black: assert property (@(posedge clk) reset |=> rgb == 12'h000)
		else $error("rgb not black after reset");

	// HAM mode comes out of reset off
	reset_ham_off: assert property (@(posedge clk) reset |=> !ham_mode)
		else $error("ham_mode set after reset");

endmodule

bind video_mixer denise_props i_denise_props (
	.clk      (clk),
	.reset    (reset),
	.blank    (blank),
	.ham_mode (ham_mode),
	.rgb      (rgb)
);

`default_nettype wire

// File: tests/tb_denise.sv
// testbench for the colour path checking random pixels against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_denise;

	// --------------------
	// run length in clock cycles
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int SETUP_CYCLES = 36; // palette load, clxdat read, idle
	localparam int BASIC_PIXELS = 200;
	localparam int PRIO_BLOCKS = 4;
	localparam int PRIO_PIXELS = 50;  // per pf_priority value
	localparam int HAM_PIXELS = 200;
	localparam int CLX_PIXELS = 100;
	localparam int BLANK_PIXELS = 200;
	localparam int TOTAL_CYCLES = RESET_CYCLES + SETUP_CYCLES + 2 + BASIC_PIXELS +
		PRIO_BLOCKS * (PRIO_PIXELS + 1) + HAM_PIXELS + 2 + CLX_PIXELS + 3 +
		BLANK_PIXELS + 6 * 2;
	localparam int WATCHDOG_NS = (TOTAL_CYCLES + 200) * CLK_PERIOD;

	logic clk;
	logic reset;
	denise_pkg::reg_bus_t bus;
	denise_pkg::pixel_t pixel;
	logic blank;
	logic [15:0] read_data;
	denise_pkg::rgb_t rgb;

	// inputs held in the current cycle
	denise_pkg::pixel_t cur_pixel;
	logic cur_blank;
	denise_pkg::reg_bus_t cur_bus;

	// --------------------
	// reference model state
	denise_pkg::rgb_t m_pal [32]; // palette whose first 16 entries also serve HAM
	denise_pkg::rgb_t m_ham;      // HAM colour register
	denise_pkg::rgb_t m_rgb;      // output register
	logic m_sel_d;                // delay stage
	logic [3:0] m_data_d;
	logic [5:0] m_planes_d;
	logic m_ham_mode;
	logic [2:0] m_pf_priority;
	logic [15:0] m_clxcon;
	logic [14:0] m_clx;           // sticky collision pairs

	logic [31:0] seed;
	logic checking;               // model in step with the DUT
	int errors;
	int test_start;
	int tests_ok;
	int tests_bad;

	denise_top i_denise_top (
		.clk       (clk),
		.reset     (reset),
		.bus       (bus),
		.pixel     (pixel),
		.blank     (blank),
		.read_data (read_data),
		.rgb       (rgb)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// --------------------
	// helpers
	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic compare(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected)
		begin
			$display("** Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
			errors++;
		end
	endtask

	function automatic denise_pkg::reg_bus_t bus_word(input logic wr, input logic [7:0] addr,
		input logic [15:0] data);
		denise_pkg::reg_bus_t b;
		b.strobe = 1'b1;
		b.write = wr;
		b.addr = addr;
		b.data = data;
		return b;
	endfunction

	// takes the high bits since the low LCG bits repeat quickly
	function automatic denise_pkg::pixel_t random_pixel(input logic with_sprites);
		logic [31:0] r1;
		logic [31:0] r2;
		denise_pkg::pixel_t p;
		r1 = next_random();
		r2 = next_random();
		p.bitplanes = r1[31:26];
		if (r1[25:23] == 3'b000)
			p.bitplanes = 6'd0; // empty playfield now and then
		p.sprite_data = r1[21:18];
		p.sprite_active = r2[31:24] & r2[23:16];
		if (!with_sprites || r1[17])
			p.sprite_active = 8'd0; // half the pixels without sprites
		return p;
	endfunction

	// --------------------
	// model rules
	function automatic denise_pkg::rgb_t half_brite(input denise_pkg::rgb_t c);
		denise_pkg::rgb_t h;
		h.red = c.red >> 1;
		h.green = c.green >> 1;
		h.blue = c.blue >> 1;
		return h;
	endfunction

	// front pair wins but the playfield covers codes above pf_priority
	function automatic logic sprite_wins(input denise_pkg::pixel_t p, input logic [2:0] pri);
		logic [2:0] code;
		code = 3'd0;
		for (int g = 3; g >= 0; g--)
			if (p.sprite_active[2*g] || p.sprite_active[2*g+1])
				code = 3'(g + 1);
		if (code == 3'd0)
			return 1'b0;
		if ((|p.bitplanes) && code > pri)
			return 1'b0;
		return 1'b1;
	endfunction

	function automatic logic [14:0] collisions(input denise_pkg::pixel_t p,
		input logic [15:0] con);
		logic odd_hit;
		logic even_hit;
		logic [3:0] grp;
		logic [14:0] hits;
		int n;
		odd_hit = 1'b1;
		even_hit = 1'b1;
		for (int pl = 0; pl < 6; pl++)
			if (con[6+pl] && p.bitplanes[pl] != con[pl])
			begin
				if (pl % 2 == 0)
					odd_hit = 1'b0;  // planes 1, 3, 5
				else
					even_hit = 1'b0; // planes 2, 4, 6
			end
		for (int g = 0; g < 4; g++)
			grp[g] = p.sprite_active[2*g] || (p.sprite_active[2*g+1] && con[12+g]);
		hits[0] = odd_hit && even_hit;
		for (int g = 0; g < 4; g++)
		begin
			hits[1+g] = odd_hit && grp[g];
			hits[5+g] = even_hit && grp[g];
		end
		n = 9; // sprite against sprite from here
		for (int a = 0; a < 3; a++)
			for (int b = a + 1; b < 4; b++)
			begin
				hits[n] = grp[a] && grp[b];
				n++;
			end
		return hits;
	endfunction

	function automatic logic [15:0] expected_read(input logic [7:0] addr);
		if (addr == denise_pkg::REG_DENISEID)
			return 16'hffff;
		if (addr == denise_pkg::REG_CLXDAT)
			return {1'b1, m_clx};
		return 16'h0000;
	endfunction

	// one clock edge of the model from the inputs held before it
	function automatic void advance_model();
		denise_pkg::rgb_t pick;
		logic [14:0] hits;
		if (cur_blank)
			m_rgb = 12'h000;
		else if (m_ham_mode && !m_sel_d)
			m_rgb = m_ham;
		else if (m_sel_d)
			m_rgb = m_pal[{1'b1, m_data_d}]; // sprite colours 16 to 31
		else
		begin
			pick = m_pal[m_planes_d[4:0]];
			if (m_planes_d[5])
				pick = half_brite(pick);
			m_rgb = pick;
		end
		case (cur_pixel.bitplanes[5:4])
			2'b00: m_ham = m_pal[{1'b0, cur_pixel.bitplanes[3:0]}];
			2'b01: m_ham.blue = cur_pixel.bitplanes[3:0];
			2'b10: m_ham.red = cur_pixel.bitplanes[3:0];
			default: m_ham.green = cur_pixel.bitplanes[3:0];
		endcase
		m_sel_d = sprite_wins(cur_pixel, m_pf_priority);
		m_data_d = cur_pixel.sprite_data;
		m_planes_d = cur_pixel.bitplanes;
		hits = collisions(cur_pixel, m_clxcon);
		if (cur_bus.strobe && !cur_bus.write && cur_bus.addr == denise_pkg::REG_CLXDAT)
			m_clx = hits; // read clears
		else
			m_clx = m_clx | hits;
		if (cur_bus.strobe && cur_bus.write)
		begin
			if (cur_bus.addr[7:5] == 3'b110)
				m_pal[cur_bus.addr[4:0]] = denise_pkg::rgb_t'(cur_bus.data[11:0]);
			if (cur_bus.addr == denise_pkg::REG_BPLCON0)
				m_ham_mode = cur_bus.data[11];
			if (cur_bus.addr == denise_pkg::REG_BPLCON2)
				m_pf_priority = cur_bus.data[2:0];
			if (cur_bus.addr == denise_pkg::REG_CLXCON)
				m_clxcon = cur_bus.data;
		end
	endfunction

	// --------------------
	// one cycle that checks the edge just taken and then drives the next inputs
	task automatic step(input denise_pkg::pixel_t pix, input logic blk,
		input denise_pkg::reg_bus_t b);
		@(posedge clk);
		#5;
		advance_model();
		if (checking)
			compare("rgb", {4'h0, rgb}, {4'h0, m_rgb});
		pixel = pix;
		blank = blk;
		bus = b;
		cur_pixel = pix;
		cur_blank = blk;
		cur_bus = b;
		if (checking && b.strobe && !b.write)
		begin
			#20; // read data is combinational
			compare("read_data", read_data, expected_read(b.addr));
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) step('0, 1'b0, '0);
	endtask

	task automatic end_test(input int num, input string name);
		idle_cycles(2); // last pixels leave the pipeline
		if (errors == test_start)
		begin
			tests_ok++;
			$display("test %0d %s: ok", num, name);
		end
		else
		begin
			tests_bad++;
			$display("test %0d %s: %0d mismatches", num, name, errors - test_start);
		end
		test_start = errors;
	endtask

	// --------------------
	// watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		logic [31:0] r;
		clk = 1'b0;
		reset = 1'b1;
		bus = '0;
		pixel = '0;
		blank = 1'b0;
		cur_bus = '0;
		cur_pixel = '0;
		cur_blank = 1'b0;
		seed = 32'h318a_2c7c;
		checking = 1'b0;
		errors = 0;
		test_start = 0;
		tests_ok = 0;
		tests_bad = 0;
		for (int i = 0; i < 32; i++)
			m_pal[i] = 12'h000;
		m_ham = 12'h000;
		m_rgb = 12'h000;
		m_sel_d = 1'b0;
		m_data_d = 4'd0;
		m_planes_d = 6'd0;
		m_ham_mode = 1'b0;
		m_pf_priority = 3'd0;
		m_clxcon = 16'h0fff;
		m_clx = 15'd0;
		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		reset = 1'b0;

		// load every palette word and clear clxdat
		for (int i = 0; i < 32; i++)
		begin
			r = next_random();
			step('0, 1'b0, bus_word(1'b1, denise_pkg::REG_COLOR_BASE + 8'(i), r[31:16]));
		end
		step('0, 1'b0, bus_word(1'b0, denise_pkg::REG_CLXDAT, 16'h0000));
		idle_cycles(3);
		checking = 1'b1;

		// chip id and unused address
		step('0, 1'b0, bus_word(1'b0, denise_pkg::REG_DENISEID, 16'h0000));
		step('0, 1'b0, bus_word(1'b0, 8'h10, 16'h0000));
		end_test(1, "register reads");

		for (int i = 0; i < BASIC_PIXELS; i++)
			step(random_pixel(1'b0), 1'b0, '0);
		end_test(2, "palette and EHB");

		for (int k = 0; k < PRIO_BLOCKS; k++)
		begin
			r = next_random();
			step(random_pixel(1'b1), 1'b0,
				bus_word(1'b1, denise_pkg::REG_BPLCON2, {13'd0, r[31:29]}));
			for (int i = 0; i < PRIO_PIXELS; i++)
				step(random_pixel(1'b1), 1'b0, '0);
		end
		end_test(3, "sprite priority");

		step(random_pixel(1'b1), 1'b0, bus_word(1'b1, denise_pkg::REG_BPLCON0, 16'h0800));
		for (int i = 0; i < HAM_PIXELS; i++)
			step(random_pixel(1'b1), 1'b0, '0);
		step(random_pixel(1'b1), 1'b0, bus_word(1'b1, denise_pkg::REG_BPLCON0, 16'h0000));
		end_test(4, "HAM");

		r = next_random();
		step('0, 1'b0, bus_word(1'b1, denise_pkg::REG_CLXCON, r[31:16]));
		for (int i = 0; i < CLX_PIXELS; i++)
			step(random_pixel(1'b1), 1'b0, '0);
		step(random_pixel(1'b1), 1'b0, bus_word(1'b0, denise_pkg::REG_CLXDAT, 16'h0000));
		step(random_pixel(1'b1), 1'b0, bus_word(1'b0, denise_pkg::REG_CLXDAT, 16'h0000));
		end_test(5, "collisions");

		for (int i = 0; i < BLANK_PIXELS; i++)
		begin
			r = next_random();
			step(random_pixel(1'b1), r[31:30] == 2'b00, '0); // blank one pixel in four
		end
		end_test(6, "blanking");

		$display("%0d tests ok, %0d tests failed, %0d mismatches", tests_ok, tests_bad, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
